//--- common/hist_defines.svh
`ifndef HIST_DEFINES_SVH
`define HIST_DEFINES_SVH

// --------------------
// histogram geometry
// --------------------

// width of a bin index, so the histogram has 2**HIST_BIN_BITS bins.
`define HIST_BIN_BITS 6

// width of one bin counter. counts stop at the all-ones value.
`define HIST_COUNT_BITS 8

// --------------------
// acquisition control
// --------------------

// width of the laser cycle target and of the cycle counter.
`define HIST_CYCLE_BITS 16

// low code bits that are dropped in coarse mode.
`define HIST_COARSE_SHIFT 2

`endif

//--- common/hist_pkg.sv
`include "hist_defines.svh"

package hist_pkg;

    // --------------------
    // builder phases
    // --------------------

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        COUNT,
        DRAIN,
        READOUT,
        FINISH
    } state_e;

    // --------------------
    // datapath words
    // --------------------

    // one hit from the TDC.
    typedef struct packed {
        logic                        valid;
        logic [`HIST_BIN_BITS-1:0]   code;
    } hit_t;

    // one word of the readout stream.
    typedef struct packed {
        logic                        valid;
        logic [`HIST_BIN_BITS-1:0]   index;
        logic [`HIST_COUNT_BITS-1:0] count;
    } bin_out_t;

    typedef struct packed {
        logic [`HIST_BIN_BITS-1:0]   index;
        logic [`HIST_COUNT_BITS-1:0] count;
    } peak_t;

endpackage

//--- common/hist_cfg_pkg.sv
`include "hist_defines.svh"

package hist_cfg_pkg;

    // --------------------
    // write opcodes
    // --------------------

    typedef enum logic [1:0] {
        SET_CYCLES,  // cfg_data holds the laser cycle target.
        SET_MODE,    // bit 0 of cfg_data selects coarse bins.
        START
    } cfg_op_e;

    // --------------------
    // held configuration
    // --------------------

    // stays constant while a run is in progress.
    typedef struct packed {
        logic [`HIST_CYCLE_BITS-1:0] cycles;
        logic                        coarse;
    } cfg_t;

endpackage

//--- src/hist_cfg_regs.sv
`include "hist_defines.svh"

module hist_cfg_regs (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          cfg_wr,
    input  hist_cfg_pkg::cfg_op_e         cfg_op,
    input  logic [`HIST_CYCLE_BITS-1:0]   cfg_data,
    input  logic                          busy,
    output hist_cfg_pkg::cfg_t            cfg,
    output logic                          start
);

    localparam logic [`HIST_CYCLE_BITS-1:0] cycles_rst = 1;

    logic wr_ok;

    // a running acquisition locks the configuration.
    assign wr_ok = cfg_wr && !busy;

    // --------------------
    // held configuration
    // --------------------

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            cfg.cycles <= cycles_rst;
            cfg.coarse <= 1'b0;  // fine mode out of reset.
        end else if (wr_ok) begin
            case (cfg_op)
                hist_cfg_pkg::SET_CYCLES: begin
                    cfg.cycles <= cfg_data;
                end
                hist_cfg_pkg::SET_MODE: begin
                    cfg.coarse <= cfg_data[0];
                end
                default: begin
                    cfg <= cfg;
                end
            endcase
        end
    end

    // --------------------
    // start strobe
    // --------------------

    // the start pulse is decoded in the write cycle itself so that the
    // builder leaves idle on the very next edge.
    assign start = wr_ok && (cfg_op == hist_cfg_pkg::START);

endmodule

//--- hist_builder/hist_bin_ram.sv
`include "hist_defines.svh"

module hist_bin_ram (
    input  logic                          clk,
    input  logic [`HIST_BIN_BITS-1:0]     addr,
    input  logic                          we,
    input  logic [`HIST_COUNT_BITS-1:0]   wdata,
    output logic [`HIST_COUNT_BITS-1:0]   rdata
);

    localparam int depth = 1 << `HIST_BIN_BITS;

    logic [`HIST_COUNT_BITS-1:0] mem [0:depth-1];
    logic [`HIST_BIN_BITS-1:0]   addr_q;  // address of the word now on rdata.

    // The port works as a read-modify-write port. The read is registered,
    // and a write lands at the address that was read one cycle earlier,
    // which is the word whose data is on rdata during the write.
    // A read of the word being written returns the old value.

    always_ff @(posedge clk) begin
        addr_q <= addr;
        rdata  <= mem[addr];
        if (we) begin
            mem[addr_q] <= wdata;
        end
    end

endmodule

//--- hist_builder/hist_builder_fsm.sv
`include "hist_defines.svh"

module hist_builder_fsm (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          start,
    input  hist_cfg_pkg::cfg_t            cfg,
    input  hist_pkg::hit_t                hit,
    input  logic                          cycle_end,
    input  logic [`HIST_COUNT_BITS-1:0]   rdata,
    output logic [`HIST_BIN_BITS-1:0]     addr,
    output logic                          we,
    output logic [`HIST_COUNT_BITS-1:0]   wdata,
    output logic                          busy,
    output logic                          counting,
    output logic                          done,
    output hist_pkg::bin_out_t            out
);

    localparam logic [`HIST_BIN_BITS-1:0]   bin_one = 1;
    localparam logic [`HIST_COUNT_BITS-1:0] cnt_one = 1;
    localparam logic [`HIST_CYCLE_BITS-1:0] cyc_one = 1;

    hist_pkg::state_e state;
    hist_pkg::state_e state_nxt;

    logic [`HIST_BIN_BITS-1:0]   ptr;       // clear, drain and readout position.
    logic                        rd_tail;
    logic                        clr_we;
    logic [`HIST_CYCLE_BITS-1:0] cyc_cnt;
    logic                        cyc_last;
    logic [`HIST_BIN_BITS-1:0]   hit_map;
    logic                        s1_valid;  // read stage.
    logic [`HIST_BIN_BITS-1:0]   s1_bin;
    logic                        s2_valid;  // write stage.
    logic [`HIST_BIN_BITS-1:0]   s2_bin;
    logic                        fwd_valid;
    logic [`HIST_COUNT_BITS-1:0] fwd_data;
    logic [`HIST_COUNT_BITS-1:0] base;
    logic [`HIST_COUNT_BITS-1:0] incr;
    logic                        rd_valid;
    logic [`HIST_BIN_BITS-1:0]   rd_index;

    // --------------------
    // phase sequencing
    // --------------------

    assign cyc_last = cycle_end && ((cyc_cnt + cyc_one) == cfg.cycles);

    always_comb begin
        state_nxt = state;
        case (state)
            hist_pkg::IDLE: begin
                if (start) begin
                    state_nxt = hist_pkg::CLEAR;
                end
            end
            hist_pkg::CLEAR: begin
                if (ptr == '1) begin
                    // a zero target skips counting altogether.
                    state_nxt = (cfg.cycles == '0) ? hist_pkg::DRAIN : hist_pkg::COUNT;
                end
            end
            hist_pkg::COUNT: begin
                if (cyc_last) begin
                    state_nxt = hist_pkg::DRAIN;
                end
            end
            hist_pkg::DRAIN: begin
                if (ptr[0]) begin
                    state_nxt = hist_pkg::READOUT;
                end
            end
            hist_pkg::READOUT: begin
                if (rd_tail) begin
                    state_nxt = hist_pkg::FINISH;
                end
            end
            hist_pkg::FINISH: begin
                state_nxt = start ? hist_pkg::CLEAR : hist_pkg::IDLE;
            end
            default: begin
                state_nxt = hist_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= hist_pkg::IDLE;
            ptr       <= '0;
            rd_tail   <= 1'b0;
            clr_we    <= 1'b0;
            cyc_cnt   <= '0;
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            fwd_valid <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            state    <= state_nxt;
            clr_we   <= (state == hist_pkg::CLEAR);  // the write trails the address.
            s1_valid <= (state == hist_pkg::COUNT) && hit.valid;
            s2_valid <= s1_valid;
            // the read in stage 1 missed the write that stage 2 makes now.
            fwd_valid <= s1_valid && s2_valid && (s1_bin == s2_bin);
            rd_valid  <= (state == hist_pkg::READOUT) && !rd_tail;
            case (state)
                hist_pkg::CLEAR: begin
                    ptr <= ptr + bin_one;  // wraps to zero for the drain.
                end
                hist_pkg::COUNT: begin
                    if (cycle_end) begin
                        cyc_cnt <= cyc_cnt + cyc_one;
                    end
                end
                hist_pkg::DRAIN: begin
                    ptr <= ptr[0] ? '0 : ptr + bin_one;
                end
                hist_pkg::READOUT: begin
                    if (!rd_tail) begin
                        ptr <= ptr + bin_one;
                        rd_tail <= (ptr == '1);
                    end else begin
                        rd_tail <= 1'b0;
                    end
                end
                default: begin
                    ptr     <= '0;
                    cyc_cnt <= '0;
                    rd_tail <= 1'b0;
                end
            endcase
        end
    end

    // --------------------
    // count pipeline
    // --------------------

    assign hit_map = cfg.coarse ? (hit.code >> `HIST_COARSE_SHIFT) : hit.code;

    always_ff @(posedge clk) begin
        s1_bin   <= hit_map;
        s2_bin   <= s1_bin;
        fwd_data <= incr;
        rd_index <= ptr;
    end

    assign base = fwd_valid ? fwd_data : rdata;
    assign incr = (base == '1) ? base : base + cnt_one;  // saturating add.

    // --------------------
    // memory port and outputs
    // --------------------

    assign addr  = (state == hist_pkg::COUNT || state == hist_pkg::DRAIN) ? s1_bin : ptr;
    assign we    = clr_we || s2_valid;
    assign wdata = clr_we ? '0 : incr;

    assign busy     = (state != hist_pkg::IDLE) && (state != hist_pkg::FINISH);
    assign counting = (state == hist_pkg::COUNT);
    assign done     = (state == hist_pkg::FINISH);

    assign out = '{valid: rd_valid, index: rd_index, count: rdata};

endmodule

//--- hist_builder/hist_peak_tracker.sv
`include "hist_defines.svh"

module hist_peak_tracker (
    input  logic               clk,
    input  logic               res,
    input  hist_pkg::bin_out_t bin,
    output hist_pkg::peak_t    peak
);

    logic first;
    logic higher;
    logic take;

    // --------------------
    // compare
    // --------------------

    // index 0 opens a new readout and always loads.
    assign first  = (bin.index == '0);
    assign higher = (bin.count > peak.count);  // a tie keeps the lower index.
    assign take   = bin.valid && (first || higher);

    // --------------------
    // held maximum
    // --------------------

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peak <= '0;
        end else if (take) begin
            peak <= '{index: bin.index, count: bin.count};
        end
    end

    // The last word of a readout is taken on the edge before done, so the
    // peak output is final when done is high.

endmodule

//--- src/hist_top.sv
`include "hist_defines.svh"

module hist_top (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          cfg_wr,
    input  hist_cfg_pkg::cfg_op_e         cfg_op,
    input  logic [`HIST_CYCLE_BITS-1:0]   cfg_data,
    input  logic                          hit,
    input  logic [`HIST_BIN_BITS-1:0]     hit_bin,
    input  logic                          cycle_end,
    output logic                          busy,
    output logic                          counting,
    output logic                          done,
    output hist_pkg::bin_out_t            out,
    output hist_pkg::peak_t               peak
);

    hist_cfg_pkg::cfg_t          cfg;
    hist_pkg::hit_t              hit_s;
    logic                        start;
    logic [`HIST_BIN_BITS-1:0]   ram_addr;
    logic                        ram_we;
    logic [`HIST_COUNT_BITS-1:0] ram_wdata;
    logic [`HIST_COUNT_BITS-1:0] ram_rdata;

    assign hit_s = '{valid: hit, code: hit_bin};

    hist_cfg_regs hist_cfg_regs_i (
        .clk      (clk),
        .res      (res),
        .cfg_wr   (cfg_wr),
        .cfg_op   (cfg_op),
        .cfg_data (cfg_data),
        .busy     (busy),
        .cfg      (cfg),
        .start    (start)
    );

    hist_builder_fsm hist_builder_fsm_i (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .cfg       (cfg),
        .hit       (hit_s),
        .cycle_end (cycle_end),
        .rdata     (ram_rdata),
        .addr      (ram_addr),
        .we        (ram_we),
        .wdata     (ram_wdata),
        .busy      (busy),
        .counting  (counting),
        .done      (done),
        .out       (out)
    );

    hist_bin_ram hist_bin_ram_i (
        .clk   (clk),
        .addr  (ram_addr),
        .we    (ram_we),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    hist_peak_tracker hist_peak_tracker_i (
        .clk  (clk),
        .res  (res),
        .bin  (out),
        .peak (peak)
    );

endmodule

//--- sim/hist_tb.sv
`include "hist_defines.svh"

module hist_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int nbins   = 1 << `HIST_BIN_BITS;
    localparam int timeout = 2000;

    logic                          clk;
    logic                          res;
    logic                          cfg_wr;
    hist_cfg_pkg::cfg_op_e         cfg_op;
    logic [`HIST_CYCLE_BITS-1:0]   cfg_data;
    logic                          hit;
    logic [`HIST_BIN_BITS-1:0]     hit_bin;
    logic                          cycle_end;
    logic                          busy;
    logic                          counting;
    logic                          done;
    hist_pkg::bin_out_t            out;
    hist_pkg::peak_t               peak;

    int hit_log[$];          // raw codes of every hit taken while counting.
    int exp_cnt[nbins];
    int exp_peak_idx;
    int errors;
    int checks;
    int words;
    int cyc_seen;
    int run_target;
    bit run_coarse;

    hist_top hist_top_i (
        .clk       (clk),
        .res       (res),
        .cfg_wr    (cfg_wr),
        .cfg_op    (cfg_op),
        .cfg_data  (cfg_data),
        .hit       (hit),
        .hit_bin   (hit_bin),
        .cycle_end (cycle_end),
        .busy      (busy),
        .counting  (counting),
        .done      (done),
        .out       (out),
        .peak      (peak)
    );

    always #10 clk = ~clk;

    // --------------------
    // reference model
    // --------------------

    function automatic void reference_histogram(input bit coarse, input int width);
        int maxv;
        int b;
        maxv = (1 << width) - 1;
        for (int i = 0; i < nbins; i++) begin
            exp_cnt[i] = 0;
        end
        foreach (hit_log[k]) begin
            b = coarse ? (hit_log[k] >> `HIST_COARSE_SHIFT) : hit_log[k];
            if (exp_cnt[b] < maxv) begin
                exp_cnt[b]++;  // counters stick at all ones.
            end
        end
        exp_peak_idx = 0;
        for (int i = 1; i < nbins; i++) begin
            if (exp_cnt[i] > exp_cnt[exp_peak_idx]) begin
                exp_peak_idx = i;
            end
        end
    endfunction

    // --------------------
    // comparing process
    // --------------------

    always @(posedge clk) begin
        if (counting && hit) begin
            hit_log.push_back(int'(hit_bin));
        end
        if (counting && cycle_end) begin
            cyc_seen++;
        end
        if (out.valid) begin
            if (words == 0) begin
                reference_histogram(run_coarse, `HIST_COUNT_BITS);
            end
            checks += 2;
            assert (int'(out.index) == words) else begin
                $display("[FAIL] out.index expected %h got %h", words, out.index);
                errors++;
            end
            if (words < nbins) begin
                assert (int'(out.count) == exp_cnt[words]) else begin
                    $display("[FAIL] out.count bin %h expected %h got %h",
                             words, exp_cnt[words], out.count);
                    errors++;
                end
            end
            words++;
        end
        if (done) begin
            checks += 4;
            assert (words == nbins) else begin
                $display("readout gave %0d words instead of %0d", words, nbins);
                errors++;
            end
            assert (int'(peak.index) == exp_peak_idx) else begin
                $display("[FAIL] peak.index expected %h got %h", exp_peak_idx, peak.index);
                errors++;
            end
            assert (int'(peak.count) == exp_cnt[exp_peak_idx]) else begin
                $display("[FAIL] peak.count expected %h got %h",
                         exp_cnt[exp_peak_idx], peak.count);
                errors++;
            end
            assert (cyc_seen == run_target) else begin
                $display("done came after %0d laser cycles, target was %0d",
                         cyc_seen, run_target);
                errors++;
            end
            words    = 0;
            cyc_seen = 0;
        end
    end

    // --------------------
    // helper tasks
    // --------------------

    task automatic print_summary();
        $display("checks: %0d, errors: %0d", checks, errors);
    endtask

    task automatic abort(input string msg);
        $display("%s", msg);
        print_summary();
        $display("Regression failed");
        $finish;
    endtask

    task automatic step(input logic h, input int b, input logic ce);
        @(posedge clk);
        hit       <= h;
        hit_bin   <= `HIST_BIN_BITS'(b);
        cycle_end <= ce;
    endtask

    task automatic cfg_write(input hist_cfg_pkg::cfg_op_e op, input int data);
        @(posedge clk);
        cfg_wr   <= 1'b1;
        cfg_op   <= op;
        cfg_data <= `HIST_CYCLE_BITS'(data);
        @(posedge clk);
        cfg_wr   <= 1'b0;
    endtask

    task automatic wait_counting(input logic level);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > timeout) begin
                abort("timeout while waiting for counting to change");
            end
        end while (counting !== level);
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > timeout) begin
                abort("timeout while waiting for done");
            end
        end while (done !== 1'b1);
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (busy !== 1'b0) begin
            @(posedge clk);
            n++;
            if (n > timeout) begin
                abort("timeout while waiting for busy to fall");
            end
        end
    endtask

    task automatic configure(input bit coarse, input int target);
        cfg_write(hist_cfg_pkg::SET_MODE, int'(coarse));
        cfg_write(hist_cfg_pkg::SET_CYCLES, target);
        run_coarse = coarse;
        run_target = target;
        hit_log.delete();
    endtask

    task automatic start_run(input bit coarse, input int target);
        configure(coarse, target);
        cfg_write(hist_cfg_pkg::START, 0);
        wait_counting(1'b1);
    endtask

    task automatic finish_run();
        wait_done();
        wait_not_busy();
    endtask

    task automatic burst(input int b, input int n);
        repeat (n) step(1'b1, b, 1'b0);
        step(1'b0, 0, 1'b0);
    endtask

    task automatic end_cycle();
        step(1'b0, 0, 1'b1);
        step(1'b0, 0, 1'b0);
    endtask

    // random hits per laser cycle. a bin is often repeated to build bursts.
    task automatic random_cycles(input int n, input int pct);
        int len;
        int b;
        b = 0;
        for (int c = 0; c < n; c++) begin
            len = 4 + int'($urandom % 12);
            for (int k = 0; k < len; k++) begin
                if (int'($urandom % 100) < pct) begin
                    if ($urandom % 2 == 0) begin
                        b = int'($urandom % nbins);
                    end
                    step(1'b1, b, 1'b0);
                end else begin
                    step(1'b0, 0, 1'b0);
                end
            end
            step(1'b0, 0, 1'b1);
        end
        step(1'b0, 0, 1'b0);
    endtask

    task automatic check_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            checks++;
            assert (busy === 1'b0) else begin
                $display("a second run started after a start written while busy");
                errors++;
            end
        end
    endtask

    // --------------------
    // test sequence
    // --------------------

    initial begin
        void'($urandom(74));
        clk       = 1'b0;
        res       = 1'b0;
        cfg_wr    = 1'b0;
        cfg_op    = hist_cfg_pkg::SET_CYCLES;
        cfg_data  = '0;
        hit       = 1'b0;
        hit_bin   = '0;
        cycle_end = 1'b0;
        errors    = 0;
        checks    = 0;
        words     = 0;
        cyc_seen  = 0;
        run_target = 1;
        run_coarse = 1'b0;
        repeat (3) @(posedge clk);
        res <= 1'b1;

        start_run(1'b0, 6);  // heavy fine mode run.
        random_cycles(6, 70);
        finish_run();

        start_run(1'b0, 2);  // light run shows only its own hits.
        random_cycles(2, 10);
        finish_run();

        start_run(1'b1, 4);
        random_cycles(4, 50);
        finish_run();

        start_run(1'b0, 1);
        burst(10, 300);
        burst(9, 3);
        burst(11, 2);
        end_cycle();
        finish_run();

        start_run(1'b0, 1);
        burst(40, 5);
        burst(20, 5);
        burst(33, 4);
        end_cycle();
        finish_run();
        checks++;
        assert (peak.index == 20 && peak.count == 5) else begin
            $display("[FAIL] peak expected %h/%h got %h/%h", 20, 5, peak.index, peak.count);
            errors++;
        end

        // stray hits around the counting window and writes while busy.
        configure(1'b0, 3);
        cfg_write(hist_cfg_pkg::START, 0);
        for (int i = 0; i < 10; i++) begin
            step(1'b1, i, i[0]);
        end
        step(1'b0, 0, 1'b0);
        wait_counting(1'b1);
        cfg_write(hist_cfg_pkg::START, 0);
        cfg_write(hist_cfg_pkg::SET_CYCLES, 1);
        random_cycles(3, 30);
        for (int i = 0; i < 6; i++) begin
            step(1'b1, 5, 1'b1);
        end
        step(1'b0, 0, 1'b0);
        finish_run();
        check_idle(20);

        print_summary();
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+common
common/hist_pkg.sv
common/hist_cfg_pkg.sv
src/hist_cfg_regs.sv
hist_builder/hist_bin_ram.sv
hist_builder/hist_builder_fsm.sv
hist_builder/hist_peak_tracker.sv
src/hist_top.sv
sim/hist_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the histogram testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module hist_tb -o hist_sim

./obj_dir/hist_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi

if ! grep -q "Regression passed" sim.log; then
    exit 1
fi

exit 0
